// ==== src/zynq_shell_cfg.svh ====
`ifndef ZYNQ_SHELL_CFG_SVH
`define ZYNQ_SHELL_CFG_SVH

// host register word width
`define SHELL_DATA_W 32

// DRAM address width on both sides of the remap
`define SHELL_ADDR_W 32

// number of host-written control registers
`define SHELL_NUM_CSR 4

// core DRAM base, xor-ed out before the host window base is added
`define SHELL_DRAM_XOR 32'h8000_0000

// one profiler bit per 8 MB region
`define SHELL_PROF_REGIONS 128

// default depth of the tag bit queue
`define SHELL_BB_DEPTH 4

`endif

// ==== src/shell_csr_pkg.sv ====
`include "zynq_shell_cfg.svh"

package shell_csr_pkg;

   localparam int csr_index_w_lp = $clog2(`SHELL_NUM_CSR);

   ////////////////////////////////////////
   // host register map
   ////////////////////////////////////////

   // CSR_RESETN is the low-true system reset
   // CSR_DRAM_BASE holds the host-allocated DRAM window base
   typedef enum logic [csr_index_w_lp-1:0] {
      CSR_RESETN    = 0,
      CSR_BITBANG   = 1,
      CSR_DRAM_INIT = 2,
      CSR_DRAM_BASE = 3
   } csr_index_e;

endpackage

// ==== src/shell_addr_pkg.sv ====
`include "zynq_shell_cfg.svh"

package shell_addr_pkg;

   localparam int region_w_lp = $clog2(`SHELL_PROF_REGIONS);
   localparam int offset_w_lp = `SHELL_ADDR_W - 2 - region_w_lp;

   // index of one 8 MB region in the memory-use map
   typedef logic [region_w_lp-1:0] prof_region_t;

   // profiler view of a core DRAM address
   // region sits at bits 29 to 23
   typedef struct packed {
      logic [1:0]             high;
      prof_region_t           region;
      logic [offset_w_lp-1:0] offset;
   } core_addr_fields_s;

   // read as raw by the remap and as fields by the profiler
   typedef union packed {
      logic [`SHELL_ADDR_W-1:0] raw;
      core_addr_fields_s        fields;
   } core_addr_u;

endpackage

// ==== src/shell_csr_bank.sv ====
`timescale 1ns/1ns

`include "zynq_shell_cfg.svh"

module shell_csr_bank
   import shell_csr_pkg::*;
   (input  logic                     aclk
   , input  logic                     reset_i

   // host write strobe
   , input  logic                     csr_we_i
   , input  csr_index_e               csr_addr_i
   , input  logic [`SHELL_DATA_W-1:0] csr_wdata_i

   // decoded controls
   , output logic                     sys_resetn_o
   , output logic                     dram_init_o
   , output logic [`SHELL_ADDR_W-1:0] dram_base_o

   // one pulse per bit-bang write
   , output logic                     bb_v_o
   , output logic                     bb_bit_o
   );

   logic [`SHELL_DATA_W-1:0] csr_r [`SHELL_NUM_CSR];
   logic                     bb_v_r;

   ////////////////////////////////////////
   // register file
   ////////////////////////////////////////

   // all registers clear so the system sits in reset afterwards
   always_ff @(posedge aclk) begin
      if (reset_i) begin
         for (int i = 0; i < `SHELL_NUM_CSR; i++) begin
            csr_r[i] <= '0;
         end
      end else if (csr_we_i) begin
         csr_r[csr_addr_i] <= csr_wdata_i;
      end
   end

   // new-data flag for the bit-bang register
   // high for the one cycle after each write
   always_ff @(posedge aclk) begin
      if (reset_i) begin
         bb_v_r <= 1'b0;
      end else begin
         bb_v_r <= csr_we_i && (csr_addr_i == CSR_BITBANG);
      end
   end

   ////////////////////////////////////////
   // outputs
   ////////////////////////////////////////

   // sys_resetn is active low
   assign sys_resetn_o = csr_r[CSR_RESETN][0];
   assign dram_init_o  = csr_r[CSR_DRAM_INIT][0];
   assign dram_base_o  = csr_r[CSR_DRAM_BASE][`SHELL_ADDR_W-1:0];

   // the bit rides in the register itself, valid alongside the pulse
   assign bb_v_o   = bb_v_r;
   assign bb_bit_o = csr_r[CSR_BITBANG][0];

endmodule

// ==== src/tag_bit_fifo.sv ====
`timescale 1ns/1ns

`include "zynq_shell_cfg.svh"

module tag_bit_fifo
   #(parameter int depth_p = `SHELL_BB_DEPTH)
   (input  logic aclk
   , input  logic reset_i

   // plain strobe from the register bank, no ready
   , input  logic bb_v_i
   , input  logic bb_bit_i

   // valid/ready_and toward the serializer
   , output logic v_o
   , output logic bit_o
   , input  logic ready_and_i
   );

   localparam int ptr_w_lp = $clog2(depth_p);
   localparam int cnt_w_lp = $clog2(depth_p + 1);

   logic [depth_p-1:0]  mem_r;
   logic [ptr_w_lp-1:0] rd_ptr_r;
   logic [ptr_w_lp-1:0] wr_ptr_r;
   logic [cnt_w_lp-1:0] count_r;
   logic                full;
   logic                push;
   logic                pop;

   // pointers wrap at depth_p so any depth works
   function automatic logic [ptr_w_lp-1:0] ptr_next(input logic [ptr_w_lp-1:0] ptr);
      return (ptr == ptr_w_lp'(depth_p - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full = (count_r == cnt_w_lp'(depth_p));
   assign pop  = v_o && ready_and_i;
   // a full queue still takes a bit when the head leaves the same cycle
   assign push = bb_v_i && (!full || pop);

   assign v_o   = (count_r != '0);
   assign bit_o = mem_r[rd_ptr_r];

   always_ff @(posedge aclk) begin
      if (push) begin
         mem_r[wr_ptr_r] <= bb_bit_i;
      end
   end

   always_ff @(posedge aclk) begin
      if (reset_i) begin
         rd_ptr_r <= '0;
         wr_ptr_r <= '0;
         count_r  <= '0;
      end else begin
         if (push) begin
            wr_ptr_r <= ptr_next(wr_ptr_r);
         end
         if (pop) begin
            rd_ptr_r <= ptr_next(rd_ptr_r);
         end
         if (push && !pop) begin
            count_r <= count_r + 1'b1;
         end else if (pop && !push) begin
            count_r <= count_r - 1'b1;
         end
      end
   end

   // a strobe into a full queue loses a tag bit
   assert property (@(posedge aclk) disable iff (reset_i) bb_v_i |-> (!full || pop))
      else $error("tag_bit_fifo: bitbang bit drop occurred");

   // equal pointers only when empty or full, so v_o never offers an unwritten slot
   assert property (@(posedge aclk) disable iff (reset_i)
                    (rd_ptr_r == wr_ptr_r) == ((count_r == '0) || full))
      else $error("tag_bit_fifo: pop from empty queue, count out of step with pointers");

endmodule

// ==== src/tag_bitbang.sv ====
`timescale 1ns/1ns

module tag_bitbang
   (input  logic aclk
   , input  logic reset_i

   // bits from the queue
   , input  logic v_i
   , input  logic bit_i
   , output logic ready_and_o

   // serial tag pins
   , output logic tag_clk_o
   , output logic tag_data_o
   );

   logic busy_r;
   logic tag_clk_r;
   logic tag_data_r;
   logic accept;

   // next bit loads while idle or during the clock-high phase
   // so bits stream back to back
   assign ready_and_o = !busy_r || tag_clk_r;
   assign accept      = v_i && ready_and_o;

   ////////////////////////////////////////
   // two-phase serializer
   ////////////////////////////////////////

   // phase one puts the bit out with the clock low
   // phase two raises the clock for a single cycle
   always_ff @(posedge aclk) begin
      if (reset_i) begin
         busy_r     <= 1'b0;
         tag_clk_r  <= 1'b0;
         tag_data_r <= 1'b0;
      end else if (accept) begin
         busy_r     <= 1'b1;
         tag_clk_r  <= 1'b0;
         tag_data_r <= bit_i;
      end else if (busy_r && !tag_clk_r) begin
         tag_clk_r <= 1'b1;
      end else begin
         busy_r    <= 1'b0;
         tag_clk_r <= 1'b0;
      end
   end

   assign tag_clk_o  = tag_clk_r;
   assign tag_data_o = tag_data_r;

   // receiver samples on the rising clock, data was set up a cycle earlier
   assert property (@(posedge aclk) disable iff (reset_i) tag_clk_o |-> $stable(tag_data_o))
      else $error("tag_bitbang: tag_data changed while tag_clk high");

endmodule

// ==== src/dram_remap_profiler.sv ====
`timescale 1ns/1ns

`include "zynq_shell_cfg.svh"

module dram_remap_profiler
   import shell_addr_pkg::*;
   (input  logic                     aclk
   , input  logic                     reset_i
   , input  logic                     sys_resetn_i

   // host DRAM window base
   , input  logic [`SHELL_ADDR_W-1:0] dram_base_i

   // core DRAM address channels, valids taken as levels
   , input  logic                     core_awvalid_i
   , input  core_addr_u               core_awaddr_i
   , input  logic                     core_arvalid_i
   , input  core_addr_u               core_araddr_i

   // profiler readback select, one 32-bit word each
   , input  logic [1:0]               prof_sel_i

   , output logic [`SHELL_ADDR_W-1:0] m00_awaddr_o
   , output logic [`SHELL_ADDR_W-1:0] m00_araddr_o
   , output logic [`SHELL_DATA_W-1:0] prof_word_o
   );

   logic [`SHELL_PROF_REGIONS-1:0] prof_r;
   logic                           prof_reset;

   ////////////////////////////////////////
   // DRAM remap
   ////////////////////////////////////////

   // strip the core DRAM base, then shift into the host window
   assign m00_awaddr_o = (core_awaddr_i.raw ^ `SHELL_DRAM_XOR) + dram_base_i;
   assign m00_araddr_o = (core_araddr_i.raw ^ `SHELL_DRAM_XOR) + dram_base_i;

   ////////////////////////////////////////
   // memory-use profiler
   ////////////////////////////////////////

   // map clears with the system reset as well
   assign prof_reset = reset_i || !sys_resetn_i;

   // one sticky bit per touched region
   always_ff @(posedge aclk) begin
      if (prof_reset) begin
         prof_r <= '0;
      end else begin
         if (core_awvalid_i) begin
            prof_r[core_awaddr_i.fields.region] <= 1'b1;
         end
         if (core_arvalid_i) begin
            prof_r[core_araddr_i.fields.region] <= 1'b1;
         end
      end
   end

   assign prof_word_o = prof_r[prof_sel_i * `SHELL_DATA_W +: `SHELL_DATA_W];

endmodule

// ==== src/zynq_shell_top.sv ====
`timescale 1ns/1ns

`include "zynq_shell_cfg.svh"

module zynq_shell_top
   import shell_csr_pkg::*;
   import shell_addr_pkg::*;
   (input  logic                     aclk
   , input  logic                     reset_i

   // host register writes
   , input  logic                     csr_we_i
   , input  csr_index_e               csr_addr_i
   , input  logic [`SHELL_DATA_W-1:0] csr_wdata_i

   // core DRAM address channels
   , input  logic                     core_awvalid_i
   , input  core_addr_u               core_awaddr_i
   , input  logic                     core_arvalid_i
   , input  core_addr_u               core_araddr_i

   , input  logic [1:0]               prof_sel_i

   , output logic                     sys_resetn_o
   , output logic                     dram_init_o

   , output logic                     tag_clk_o
   , output logic                     tag_data_o

   , output logic [`SHELL_ADDR_W-1:0] m00_awaddr_o
   , output logic [`SHELL_ADDR_W-1:0] m00_araddr_o
   , output logic [`SHELL_DATA_W-1:0] prof_word_o
   );

   logic [`SHELL_ADDR_W-1:0] dram_base;
   logic                     bb_v;
   logic                     bb_bit;
   logic                     q_v;
   logic                     q_bit;
   logic                     q_ready;

   ////////////////////////////////////////
   // control registers
   ////////////////////////////////////////

   shell_csr_bank csr_bank
      (.aclk         (aclk)
      ,.reset_i      (reset_i)
      ,.csr_we_i     (csr_we_i)
      ,.csr_addr_i   (csr_addr_i)
      ,.csr_wdata_i  (csr_wdata_i)
      ,.sys_resetn_o (sys_resetn_o)
      ,.dram_init_o  (dram_init_o)
      ,.dram_base_o  (dram_base)
      ,.bb_v_o       (bb_v)
      ,.bb_bit_o     (bb_bit)
      );

   ////////////////////////////////////////
   // tag bit-bang path
   ////////////////////////////////////////

   tag_bit_fifo #(.depth_p(`SHELL_BB_DEPTH)) bit_fifo
      (.aclk        (aclk)
      ,.reset_i     (reset_i)
      ,.bb_v_i      (bb_v)
      ,.bb_bit_i    (bb_bit)
      ,.v_o         (q_v)
      ,.bit_o       (q_bit)
      ,.ready_and_i (q_ready)
      );

   tag_bitbang bitbang
      (.aclk        (aclk)
      ,.reset_i     (reset_i)
      ,.v_i         (q_v)
      ,.bit_i       (q_bit)
      ,.ready_and_o (q_ready)
      ,.tag_clk_o   (tag_clk_o)
      ,.tag_data_o  (tag_data_o)
      );

   // DRAM window remap and memory-use map
   dram_remap_profiler remap_prof
      (.aclk           (aclk)
      ,.reset_i        (reset_i)
      ,.sys_resetn_i   (sys_resetn_o)
      ,.dram_base_i    (dram_base)
      ,.core_awvalid_i (core_awvalid_i)
      ,.core_awaddr_i  (core_awaddr_i)
      ,.core_arvalid_i (core_arvalid_i)
      ,.core_araddr_i  (core_araddr_i)
      ,.prof_sel_i     (prof_sel_i)
      ,.m00_awaddr_o   (m00_awaddr_o)
      ,.m00_araddr_o   (m00_araddr_o)
      ,.prof_word_o    (prof_word_o)
      );

endmodule

// ==== testbench/tb_shell_checks.sv ====
`timescale 1ns/1ns

`include "zynq_shell_cfg.svh"

module tb_shell_checks
   import shell_csr_pkg::*;
   (input  logic                     aclk
   , input  logic                     reset_i
   , input  logic                     csr_we_i
   , input  csr_index_e               csr_addr_i
   , input  logic [`SHELL_DATA_W-1:0] csr_wdata_i
   , input  logic                     core_awvalid_i
   , input  logic [`SHELL_ADDR_W-1:0] core_awaddr_i
   , input  logic                     core_arvalid_i
   , input  logic [`SHELL_ADDR_W-1:0] core_araddr_i
   , input  logic [1:0]               prof_sel_i
   , input  logic                     sys_resetn_i
   , input  logic                     dram_init_i
   , input  logic                     tag_clk_i
   , input  logic                     tag_data_i
   , input  logic [`SHELL_ADDR_W-1:0] m00_awaddr_i
   , input  logic [`SHELL_ADDR_W-1:0] m00_araddr_i
   , input  logic [`SHELL_DATA_W-1:0] prof_word_i
   );

   int                       err_count = 0;
   logic                     exp_resetn_r;
   logic                     exp_init_r;
   logic [`SHELL_ADDR_W-1:0] exp_base_r;
   logic [127:0]             map_r;
   logic [`SHELL_ADDR_W-1:0] exp_awaddr;
   logic [`SHELL_ADDR_W-1:0] exp_araddr;
   logic [`SHELL_DATA_W-1:0] exp_word;
   // ring of written tag bits, oldest at head_r
   logic                     exp_bits [64];
   logic [5:0]               head_r;
   logic [5:0]               tail_r;
   int                       pending_r;
   int                       popped_r;
   logic                     bit_push;
   logic                     bit_pop;

   ////////////////////////////////////////
   // reference models
   ////////////////////////////////////////

   always_ff @(posedge aclk) begin
      if (reset_i) begin
         exp_resetn_r <= 1'b0;
         exp_init_r   <= 1'b0;
         exp_base_r   <= '0;
      end else if (csr_we_i) begin
         case (csr_addr_i)
            CSR_RESETN:    exp_resetn_r <= csr_wdata_i[0];
            CSR_DRAM_INIT: exp_init_r   <= csr_wdata_i[0];
            CSR_DRAM_BASE: exp_base_r   <= csr_wdata_i;
            default: ;
         endcase
      end
   end

   // region index is address bits 29 to 23, one bit per 8 MB
   always_ff @(posedge aclk) begin
      if (reset_i || !exp_resetn_r) begin
         map_r <= '0;
      end else begin
         if (core_awvalid_i) begin
            map_r[core_awaddr_i[29:23]] <= 1'b1;
         end
         if (core_arvalid_i) begin
            map_r[core_araddr_i[29:23]] <= 1'b1;
         end
      end
   end

   assign exp_awaddr = (core_awaddr_i ^ 32'h8000_0000) + exp_base_r;
   assign exp_araddr = (core_araddr_i ^ 32'h8000_0000) + exp_base_r;
   assign exp_word   = map_r[prof_sel_i * 32 +: 32];

   assign bit_push = csr_we_i && (csr_addr_i == CSR_BITBANG);
   assign bit_pop  = tag_clk_i && (pending_r != 0);

   always_ff @(posedge aclk) begin
      if (reset_i) begin
         head_r    <= '0;
         tail_r    <= '0;
         pending_r <= 0;
         popped_r  <= 0;
      end else begin
         if (bit_push) begin
            exp_bits[tail_r] <= csr_wdata_i[0];
            tail_r           <= tail_r + 6'd1;
         end
         if (bit_pop) begin
            head_r   <= head_r + 6'd1;
            popped_r <= popped_r + 1;
         end
         pending_r <= pending_r + (bit_push ? 1 : 0) - (bit_pop ? 1 : 0);
      end
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   reset_state_a: assert property (@(posedge aclk)
      $fell(reset_i) |-> !(sys_resetn_i || dram_init_i || tag_clk_i || tag_data_i))
      else begin
         err_count = err_count + 1;
         $error("control or tag outputs were not low after reset");
      end

   resetn_a: assert property (@(posedge aclk) disable iff (reset_i)
      sys_resetn_i == exp_resetn_r)
      else begin
         err_count = err_count + 1;
         $error("[ERROR] sys_resetn_o got %h expected %h",
                $sampled(sys_resetn_i), $sampled(exp_resetn_r));
      end

   dram_init_a: assert property (@(posedge aclk) disable iff (reset_i)
      dram_init_i == exp_init_r)
      else begin
         err_count = err_count + 1;
         $error("[ERROR] dram_init_o got %h expected %h",
                $sampled(dram_init_i), $sampled(exp_init_r));
      end

   awaddr_a: assert property (@(posedge aclk) disable iff (reset_i)
      m00_awaddr_i == exp_awaddr)
      else begin
         err_count = err_count + 1;
         $error("[ERROR] m00_awaddr_o got %h expected %h",
                $sampled(m00_awaddr_i), $sampled(exp_awaddr));
      end

   araddr_a: assert property (@(posedge aclk) disable iff (reset_i)
      m00_araddr_i == exp_araddr)
      else begin
         err_count = err_count + 1;
         $error("[ERROR] m00_araddr_o got %h expected %h",
                $sampled(m00_araddr_i), $sampled(exp_araddr));
      end

   prof_word_a: assert property (@(posedge aclk) disable iff (reset_i)
      prof_word_i == exp_word)
      else begin
         err_count = err_count + 1;
         $error("[ERROR] prof_word_o sel %h got %h expected %h",
                $sampled(prof_sel_i), $sampled(prof_word_i), $sampled(exp_word));
      end

   tag_clk_pulse_a: assert property (@(posedge aclk) disable iff (reset_i)
      tag_clk_i |=> !tag_clk_i)
      else begin
         err_count = err_count + 1;
         $error("tag_clk_o stayed high for two cycles in a row");
      end

   tag_clk_owed_a: assert property (@(posedge aclk) disable iff (reset_i)
      tag_clk_i |-> (pending_r != 0))
      else begin
         err_count = err_count + 1;
         $error("tag_clk_o rose with no tag bit written");
      end

   tag_data_a: assert property (@(posedge aclk) disable iff (reset_i)
      bit_pop |-> (tag_data_i == exp_bits[head_r]))
      else begin
         err_count = err_count + 1;
         $error("[ERROR] tag_data_o got %h expected %h",
                $sampled(tag_data_i), $sampled(exp_bits[head_r]));
      end

endmodule

// ==== testbench/tb_zynq_shell.sv ====
`timescale 1ns/1ns

`include "zynq_shell_cfg.svh"

module tb_zynq_shell
   import shell_csr_pkg::*;
   import shell_addr_pkg::*;
   ();

   // total test length is a few hundred cycles
   localparam int timeout_cycles_lp = 3000;
   localparam int tag_bits_lp       = 20;

   logic                     aclk;
   logic                     reset_i;
   logic                     csr_we_i;
   csr_index_e               csr_addr_i;
   logic [`SHELL_DATA_W-1:0] csr_wdata_i;
   logic                     core_awvalid_i;
   core_addr_u               core_awaddr_i;
   logic                     core_arvalid_i;
   core_addr_u               core_araddr_i;
   logic [1:0]               prof_sel_i;
   logic                     sys_resetn_o;
   logic                     dram_init_o;
   logic                     tag_clk_o;
   logic                     tag_data_o;
   logic [`SHELL_ADDR_W-1:0] m00_awaddr_o;
   logic [`SHELL_ADDR_W-1:0] m00_araddr_o;
   logic [`SHELL_DATA_W-1:0] prof_word_o;
   integer                   seed;
   int                       cycle_count = 0;
   int                       end_errors = 0;

   zynq_shell_top zynq_shell_top_inst (.*);

   bind zynq_shell_top tb_shell_checks checks
      (.aclk           (aclk)
      ,.reset_i        (reset_i)
      ,.csr_we_i       (csr_we_i)
      ,.csr_addr_i     (csr_addr_i)
      ,.csr_wdata_i    (csr_wdata_i)
      ,.core_awvalid_i (core_awvalid_i)
      ,.core_awaddr_i  (core_awaddr_i)
      ,.core_arvalid_i (core_arvalid_i)
      ,.core_araddr_i  (core_araddr_i)
      ,.prof_sel_i     (prof_sel_i)
      ,.sys_resetn_i   (sys_resetn_o)
      ,.dram_init_i    (dram_init_o)
      ,.tag_clk_i      (tag_clk_o)
      ,.tag_data_i     (tag_data_o)
      ,.m00_awaddr_i   (m00_awaddr_o)
      ,.m00_araddr_i   (m00_araddr_o)
      ,.prof_word_i    (prof_word_o)
      );

   always #2 aclk = ~aclk;

   always @(posedge aclk) begin
      cycle_count <= cycle_count + 1;
   end

   ////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge aclk);
   endtask

   // one write per call, back-to-back calls give back-to-back writes
   task automatic write_csr(input csr_index_e addr, input logic [`SHELL_DATA_W-1:0] data);
      csr_we_i    = 1'b1;
      csr_addr_i  = addr;
      csr_wdata_i = data;
      @(negedge aclk);
      csr_we_i = 1'b0;
   endtask

   task automatic sweep_prof_words();
      for (int s = 0; s < 4; s++) begin
         prof_sel_i = 2'(s);
         @(negedge aclk);
      end
   endtask

   task automatic drive_core_traffic(input int n, input logic use_valid);
      logic [31:0] rnd;
      for (int i = 0; i < n; i++) begin
         core_awaddr_i.raw = $random(seed);
         core_araddr_i.raw = $random(seed);
         rnd = $random(seed);
         core_awvalid_i = use_valid & rnd[0];
         core_arvalid_i = use_valid & rnd[1];
         prof_sel_i     = rnd[3:2];
         @(negedge aclk);
      end
      core_awvalid_i = 1'b0;
      core_arvalid_i = 1'b0;
   endtask

   task automatic register_writes();
      logic [31:0] rnd;
      write_csr(CSR_RESETN, 32'h1);
      write_csr(CSR_DRAM_INIT, 32'h1);
      idle_cycles(2);
      for (int i = 0; i < 8; i++) begin
         rnd = $random(seed);
         write_csr(rnd[31] ? CSR_RESETN : CSR_DRAM_INIT, rnd);
      end
      write_csr(CSR_RESETN, 32'h1);
   endtask

   task automatic remap_random_addresses();
      for (int b = 0; b < 3; b++) begin
         write_csr(CSR_DRAM_BASE, $random(seed));
         drive_core_traffic(20, 1'b0);
      end
   endtask

   // the map is cleared by a zero in the reset register
   task automatic profile_traffic();
      drive_core_traffic(60, 1'b1);
      sweep_prof_words();
      write_csr(CSR_RESETN, 32'h0);
      sweep_prof_words();
      write_csr(CSR_RESETN, 32'h1);
      drive_core_traffic(40, 1'b1);
      sweep_prof_words();
   endtask

   // bursts never exceed the queue depth, gaps let the queue drain
   task automatic stream_tag_bits();
      logic [31:0] rnd;
      int          sent;
      int          burst;
      sent = 0;
      while (sent < tag_bits_lp) begin
         rnd   = $random(seed);
         burst = 1 + int'(rnd % `SHELL_BB_DEPTH);
         if (burst > tag_bits_lp - sent) begin
            burst = tag_bits_lp - sent;
         end
         for (int i = 0; i < burst; i++) begin
            rnd = $random(seed);
            write_csr(CSR_BITBANG, {31'b0, rnd[0]});
            sent++;
         end
         idle_cycles(4 * `SHELL_BB_DEPTH);
      end
   endtask

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////

   initial begin
      seed           = 47950;
      aclk           = 1'b0;
      reset_i        = 1'b1;
      csr_we_i       = 1'b0;
      csr_addr_i     = CSR_RESETN;
      csr_wdata_i    = '0;
      core_awvalid_i = 1'b0;
      core_awaddr_i  = '0;
      core_arvalid_i = 1'b0;
      core_araddr_i  = '0;
      prof_sel_i     = 2'd0;
      repeat (10) @(posedge aclk);
      @(negedge aclk);
      reset_i = 1'b0;
      sweep_prof_words();
      register_writes();
      remap_random_addresses();
      profile_traffic();
      stream_tag_bits();
      idle_cycles(20);
      if (zynq_shell_top_inst.checks.popped_r != tag_bits_lp) begin
         end_errors++;
         $display("only %0d of %0d tag bits came out on tag_data_o",
                  zynq_shell_top_inst.checks.popped_r, tag_bits_lp);
      end
      $display("errors: assertions %0d, end of run %0d",
               zynq_shell_top_inst.checks.err_count, end_errors);
      if (zynq_shell_top_inst.checks.err_count == 0 && end_errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   initial begin
      wait (cycle_count >= timeout_cycles_lp);
      $display("run did not finish within %0d cycles", timeout_cycles_lp);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+src
src/shell_csr_pkg.sv
src/shell_addr_pkg.sv
src/shell_csr_bank.sv
src/tag_bit_fifo.sv
src/tag_bitbang.sv
src/dram_remap_profiler.sv
src/zynq_shell_top.sv
testbench/tb_shell_checks.sv
testbench/tb_zynq_shell.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the testbench with Verilator, pass or fail from the log
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_zynq_shell
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
   --top-module "$TOP" -Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
   exit 0
fi
exit 1
